/* bit_count_unit.sv */
`default_nettype none

module bit_count_unit import crypto_pkg::*; (
    input  logic             clk_i,
    input  logic             reset_i,
    input  logic             abort_i,  // unit went inactive
    input  logic             start_i,  // one-cycle pulse
    input  logic [op_w-1:0]  op_i,
    input  logic [xlen-1:0]  rs1_i,
    input  logic [xlen-1:0]  rs2_i,
    output logic             done_o,   // one-cycle pulse
    output logic [cnt_w-1:0] count_o
);

    typedef enum logic {
        cs_idle,
        cs_run
    } cnt_state_t;

    cnt_state_t        state_q;
    logic [step_w-1:0] step_q;     // chunks consumed so far
    logic              done_q;

    logic [xlen-1:0]   work_q;     // word being scanned, shifted each step
    logic              lz_mode_q;  // scan from the top for cntz
    logic              found_q;    // first 1 already seen in cntz scan
    logic [cnt_w-1:0]  count_q;

    logic [chunk_w-1:0] chunk;
    logic               chunk_has_one;
    logic [cnt_w-1:0]   chunk_val;

    // ones in one chunk
    function automatic logic [cnt_w-1:0] ones_in(input logic [chunk_w-1:0] c);
        logic [cnt_w-1:0] n;
        n = '0;
        for (int i = 0; i < chunk_w; i++) begin
            n = n + cnt_w'(c[i]);
        end
        return n;
    endfunction

    // zeros above the first 1 of one chunk, chunk_w when empty
    function automatic logic [cnt_w-1:0] lead_zeros_in(input logic [chunk_w-1:0] c);
        logic [cnt_w-1:0] n;
        logic             hit;
        n = '0;
        hit = 1'b0;
        for (int i = chunk_w - 1; i >= 0; i--) begin
            if (c[i]) begin
                hit = 1'b1;
            end else if (!hit) begin
                n = n + 1'b1;
            end
        end
        return n;
    endfunction

    // top chunk for cntz, bottom chunk otherwise
    assign chunk = lz_mode_q ? work_q[xlen-1 -: chunk_w] : work_q[chunk_w-1:0];
    assign chunk_has_one = |chunk;

    always_comb begin
        if (lz_mode_q) begin
            chunk_val = found_q ? '0 : lead_zeros_in(chunk);  // stop after first 1
        end else begin
            chunk_val = ones_in(chunk);
        end
    end

    // control part
    always_ff @(posedge clk_i) begin
        done_q <= 1'b0;  // pulse only
        if (reset_i || abort_i) begin
            state_q <= cs_idle;
            step_q  <= '0;
        end else begin
            case (state_q)
                cs_idle: begin
                    if (start_i) begin
                        state_q <= cs_run;
                        step_q  <= '0;
                    end
                end
                cs_run: begin
                    step_q <= step_q + 1'b1;
                    if (step_q == step_w'(count_steps - 1)) begin
                        state_q <= cs_idle;  // last chunk on this edge
                        done_q  <= 1'b1;
                    end
                end
                default: begin
                    state_q <= cs_idle;
                end
            endcase
        end
    end

    // datapath, latched on start then one chunk per edge
    always_ff @(posedge clk_i) begin
        if ((state_q == cs_idle) && start_i) begin
            work_q    <= (op_i == op_hmdst) ? (rs1_i ^ rs2_i) : rs1_i;
            lz_mode_q <= (op_i == op_cntz);
            found_q   <= 1'b0;
            count_q   <= '0;
        end else if (state_q == cs_run) begin
            work_q  <= lz_mode_q ? (work_q << chunk_w) : (work_q >> chunk_w);
            found_q <= found_q | chunk_has_one;
            count_q <= count_q + chunk_val;
        end
    end

    assign done_o  = done_q;
    assign count_o = count_q;

    // done only closes a run that was in progress
    done_after_run_a: assert property (
        @(posedge clk_i) disable iff (reset_i)
        done_o |-> $past(state_q == cs_run)
    );

endmodule

`default_nettype wire

/* bit_perm_unit.sv */
`default_nettype none

module bit_perm_unit import crypto_pkg::*; (
    input  logic [op_w-1:0] op_i,
    input  logic [xlen-1:0] rs1_i,
    input  logic [xlen-1:0] rs2_i,
    output logic [xlen-1:0] perm_o
);

    operand_t        a;           // rs1 view
    operand_t        b;           // rs2 view
    logic [xlen-1:0] pack_val;
    logic [xlen-1:0] rev_val;
    logic [xlen-1:0] one_hot;
    logic [xlen-1:0] sladd_val;

    assign a = operand_t'(rs1_i);
    assign b = operand_t'(rs2_i);

    // rs2 low half on top, rs1 low half below
    assign pack_val = {b.half.lo, a.half.lo};

    // mirror rs1
    always_comb begin
        for (int i = 0; i < xlen; i++) begin
            rev_val[xlen-1-i] = a.word[i];
        end
    end

    // single bit at rs1[4:0], upper bits of rs1 ignored
    assign one_hot = xlen'(1) << a.word[shamt_w-1:0];
    assign sladd_val = one_hot + b.word;  // wraps mod 2^32

    always_comb begin
        case (op_i)
            op_pkg:   perm_o = pack_val;
            op_rvrs:  perm_o = rev_val;
            op_sladd: perm_o = sladd_val;
            default:  perm_o = '0;  // counting and reserved codes
        endcase
    end

endmodule

`default_nettype wire

/* crypto_ctrl.sv */
`default_nettype none

module crypto_ctrl import crypto_pkg::*; (
    input  logic            clk_i,
    input  logic            reset_i,
    input  logic            unit_active_i,  // level from the core
    input  logic [op_w-1:0] op_i,
    input  logic            count_done_i,   // pulse from bit counter
    output logic            count_start_o,  // pulse to bit counter
    output logic            result_load_o,  // result register enable
    output logic            ready_o         // one-cycle pulse to the core
);

    typedef enum logic [1:0] {
        cs_idle,   // waiting for active
        cs_count,  // bit counter running
        cs_done,   // ready cycle
        cs_wait    // hold result until active falls
    } ctrl_state_t;

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    logic        multi;

    assign multi = is_multi_cycle(op_i);

    // start the counter on the first active edge
    assign count_start_o = (state_q == cs_idle) && unit_active_i && multi;

    // load at once for single-cycle codes, else when count is in
    assign result_load_o = unit_active_i &&
                           (((state_q == cs_idle) && !multi) ||
                            ((state_q == cs_count) && count_done_i));

    // ready follows the load by one edge, same as result_o
    assign ready_o = (state_q == cs_done);

    always_comb begin
        state_d = state_q;  // hold by default
        case (state_q)
            cs_idle: begin
                if (unit_active_i) begin
                    state_d = multi ? cs_count : cs_done;
                end
            end
            cs_count: begin
                if (count_done_i) begin
                    state_d = cs_done;  // result loads on this edge
                end
            end
            cs_done: begin
                state_d = cs_wait;  // single pulse
            end
            cs_wait: begin
                state_d = cs_wait;  // only active low leaves
            end
            default: begin
                state_d = cs_idle;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i || !unit_active_i) begin
            state_q <= cs_idle;  // also abandons a running count
        end else begin
            state_q <= state_d;
        end
    end

    // ready never stretches past one cycle
    ready_single_cycle_a: assert property (
        @(posedge clk_i) disable iff (reset_i)
        ready_o |=> !ready_o
    );

    // core holds active until it has seen ready
    ready_only_active_a: assert property (
        @(posedge clk_i) disable iff (reset_i)
        ready_o |-> unit_active_i
    );

endmodule

`default_nettype wire

/* crypto_pkg.sv */
`default_nettype none

package crypto_pkg;

    // operand and result width
    localparam int xlen = 32;
    localparam int half_w = xlen / 2;        // pack works on halves
    localparam int shamt_w = $clog2(xlen);   // only rs1[4:0] counts for sladd

    // operation codes
    localparam int op_w = 3;
    localparam logic [op_w-1:0] op_hmdst = 3'b000;  // hamming distance
    localparam logic [op_w-1:0] op_pkg   = 3'b001;  // pack low halves
    localparam logic [op_w-1:0] op_rvrs  = 3'b010;  // bit reverse
    localparam logic [op_w-1:0] op_sladd = 3'b011;  // one-hot plus rs2
    localparam logic [op_w-1:0] op_cntz  = 3'b100;  // leading zeros
    localparam logic [op_w-1:0] op_cntp  = 3'b101;  // population count
    // 110 and 111 reserved, result zero

    // iterative counter sizing
    localparam int chunk_w = 4;                      // bits per cycle
    localparam int count_steps = xlen / chunk_w;     // 8 steps
    localparam int step_w = $clog2(count_steps);
    localparam int cnt_w = $clog2(xlen + 1);         // holds 0..32

    // two halves of an operand word
    typedef struct packed {
        logic [half_w-1:0] hi;
        logic [half_w-1:0] lo;
    } halves_t;

    // one operand word, read whole or split
    typedef union packed {
        logic [xlen-1:0] word;
        halves_t         half;
    } operand_t;

    // codes that go through the bit counter
    function automatic logic is_multi_cycle(input logic [op_w-1:0] op);
        return (op == op_hmdst) || (op == op_cntz) || (op == op_cntp);
    endfunction

endpackage

`default_nettype wire

/* crypto_unit.f */
+incdir+.
crypto_pkg.sv
crypto_ctrl.sv
bit_count_unit.sv
bit_perm_unit.sv
crypto_unit.sv
tb_crypto_unit.sv

/* crypto_unit.sv */
`default_nettype none

module crypto_unit import crypto_pkg::*; (
    input  logic            clk_i,
    input  logic            reset_i,
    input  logic            unit_active_i,  // held high while op wanted
    input  logic [op_w-1:0] op_i,
    input  logic [xlen-1:0] rs1_i,
    input  logic [xlen-1:0] rs2_i,
    output logic [xlen-1:0] result_o,
    output logic            ready_o
);

    logic             count_start;
    logic             count_done;
    logic             result_load;
    logic [cnt_w-1:0] count_value;
    logic [xlen-1:0]  perm_value;
    logic [xlen-1:0]  result_d;   // class mux output
    logic [xlen-1:0]  result_q;

    crypto_ctrl crypto_ctrl_i (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .unit_active_i (unit_active_i),
        .op_i          (op_i),
        .count_done_i  (count_done),
        .count_start_o (count_start),
        .result_load_o (result_load),
        .ready_o       (ready_o)
    );

    bit_count_unit bit_count_unit_i (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .abort_i (!unit_active_i),  // drop out when core lets go
        .start_i (count_start),
        .op_i    (op_i),
        .rs1_i   (rs1_i),
        .rs2_i   (rs2_i),
        .done_o  (count_done),
        .count_o (count_value)
    );

    bit_perm_unit bit_perm_unit_i (
        .op_i   (op_i),
        .rs1_i  (rs1_i),
        .rs2_i  (rs2_i),
        .perm_o (perm_value)
    );

    // pick datapath by op class
    always_comb begin
        case (op_i)
            op_hmdst, op_cntz, op_cntp: result_d = xlen'(count_value);  // zero extend
            op_pkg, op_rvrs, op_sladd:  result_d = perm_value;
            default:                    result_d = '0;  // reserved
        endcase
    end

    // result reads zero whenever the unit is idle
    always_ff @(posedge clk_i) begin
        if (reset_i || !unit_active_i) begin
            result_q <= '0;
        end else if (result_load) begin
            result_q <= result_d;
        end
    end

    assign result_o = result_q;

    // an inactive cycle always leaves a cleared result
    result_clear_a: assert property (
        @(posedge clk_i) disable iff (reset_i)
        !unit_active_i |=> (result_o == '0)
    );

endmodule

`default_nettype wire

/* crypto_vectors.svh */
`ifndef CRYPTO_VECTORS_SVH
`define CRYPTO_VECTORS_SVH

// columns: op, rs1, rs2, expected result
task automatic load_vector_table();
    // pack, reverse, shift-left-add
    add_vector(op_pkg,   32'h1234_5678, 32'h9abc_def0, 32'hdef0_5678);
    add_vector(op_pkg,   32'hffff_0000, 32'h0000_ffff, 32'hffff_0000);
    add_vector(op_rvrs,  32'h0000_0001, 32'h0000_0000, 32'h8000_0000);
    add_vector(op_rvrs,  32'h1234_5678, 32'hdead_beef, 32'h1e6a_2c48);
    add_vector(op_rvrs,  32'hffff_ffff, 32'h0000_0000, 32'hffff_ffff);
    add_vector(op_sladd, 32'h0000_0005, 32'h0000_0064, 32'h0000_0084);
    add_vector(op_sladd, 32'h0000_0025, 32'h0000_0000, 32'h0000_0020);  // rs1 above 31
    add_vector(op_sladd, 32'h0000_001f, 32'h8000_0000, 32'h0000_0000);  // wraps
    add_vector(op_sladd, 32'hffff_ffe0, 32'hffff_ffff, 32'h0000_0000);  // bit 0, wraps
    // hamming distance
    add_vector(op_hmdst, 32'h0000_0000, 32'h0000_0000, 32'd0);
    add_vector(op_hmdst, 32'hffff_ffff, 32'h0000_0000, 32'd32);
    add_vector(op_hmdst, 32'hffff_ffff, 32'hffff_ffff, 32'd0);
    add_vector(op_hmdst, 32'h0f0f_0f0f, 32'h00ff_00ff, 32'd16);
    // population count, rs2 ignored
    add_vector(op_cntp,  32'h0000_0000, 32'hffff_ffff, 32'd0);
    add_vector(op_cntp,  32'hffff_ffff, 32'h0000_0000, 32'd32);
    add_vector(op_cntp,  32'h8000_0001, 32'h0000_0000, 32'd2);
    add_vector(op_cntp,  32'h1234_5678, 32'h0000_0000, 32'd13);
    // leading zeros, first 1 in each chunk from the top
    add_vector(op_cntz,  32'h0000_0000, 32'h0000_0000, 32'd32);
    add_vector(op_cntz,  32'h8000_0000, 32'h0000_0000, 32'd0);
    add_vector(op_cntz,  32'hffff_ffff, 32'h0000_0000, 32'd0);
    add_vector(op_cntz,  32'h1000_0000, 32'h0000_0000, 32'd3);
    add_vector(op_cntz,  32'h0400_0000, 32'h0000_0000, 32'd5);
    add_vector(op_cntz,  32'h0020_0000, 32'hffff_ffff, 32'd10);
    add_vector(op_cntz,  32'h0001_ffff, 32'h0000_0000, 32'd15);
    add_vector(op_cntz,  32'h0000_8000, 32'h0000_0000, 32'd16);
    add_vector(op_cntz,  32'h0000_0400, 32'h0000_0000, 32'd21);
    add_vector(op_cntz,  32'h0000_0020, 32'h0000_0000, 32'd26);
    add_vector(op_cntz,  32'h0000_0001, 32'h0000_0000, 32'd31);
    // reserved codes
    add_vector(3'b110,   32'h1234_5678, 32'h9abc_def0, 32'h0000_0000);
    add_vector(3'b111,   32'hffff_ffff, 32'hffff_ffff, 32'h0000_0000);
endtask

`endif

/* tb_crypto_unit.sv */
`default_nettype none

module tb_crypto_unit import crypto_pkg::*; ();

    localparam int ready_limit = 20;  // cycles before giving up on ready

    logic            clk_i;
    logic            reset_i;
    logic            unit_active_i;
    logic [op_w-1:0] op_i;
    logic [xlen-1:0] rs1_i;
    logic [xlen-1:0] rs2_i;
    logic [xlen-1:0] result_o;
    logic            ready_o;

    // stimulus table
    logic [op_w-1:0] vec_op[$];
    logic [xlen-1:0] vec_rs1[$];
    logic [xlen-1:0] vec_rs2[$];
    logic [xlen-1:0] vec_exp[$];

    int              errors;
    int              timeouts;
    int              seed;
    logic [xlen-1:0] rnd;         // raw random word
    logic [op_w-1:0] rnd_op;
    logic [xlen-1:0] rnd_a;
    logic [xlen-1:0] rnd_b;

    crypto_unit crypto_unit_i (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .unit_active_i (unit_active_i),
        .op_i          (op_i),
        .rs1_i         (rs1_i),
        .rs2_i         (rs2_i),
        .result_o      (result_o),
        .ready_o       (ready_o)
    );

    always #20 clk_i = !clk_i;  // period 40

    task automatic add_vector(input logic [op_w-1:0] op, input logic [xlen-1:0] a,
                              input logic [xlen-1:0] b, input logic [xlen-1:0] exp);
        vec_op.push_back(op);
        vec_rs1.push_back(a);
        vec_rs2.push_back(b);
        vec_exp.push_back(exp);
    endtask

    `include "crypto_vectors.svh"

    task automatic check_value(input string name, input logic [xlen-1:0] got,
                               input logic [xlen-1:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got %h expected %h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    // counting codes take the chunked path
    function automatic int expected_latency(input logic [op_w-1:0] op);
        if (op == op_hmdst || op == op_cntz || op == op_cntp) begin
            return 10;
        end
        return 1;
    endfunction

    // reference model working one bit at a time
    function automatic logic [xlen-1:0] model_result(input logic [op_w-1:0] op,
                                                     input logic [xlen-1:0] a,
                                                     input logic [xlen-1:0] b);
        logic [xlen-1:0] r;
        logic [xlen-1:0] w;
        logic [xlen-1:0] bit_at;
        int              n;
        logic            seen;
        r = '0;
        n = 0;
        seen = 1'b0;
        bit_at = '0;
        w = (op == op_hmdst) ? (a ^ b) : a;
        case (op)
            op_hmdst, op_cntp: begin
                for (int i = 0; i < xlen; i++) begin
                    n += w[i];
                end
                r = xlen'(n);
            end
            op_pkg:   r = {b[xlen/2-1:0], a[xlen/2-1:0]};
            op_rvrs: begin
                for (int i = 0; i < xlen; i++) begin
                    r[i] = a[xlen-1-i];
                end
            end
            op_sladd: begin
                for (int i = 0; i < xlen; i++) begin
                    bit_at[i] = (a[4:0] == 5'(i));  // only rs1[4:0] counts
                end
                r = bit_at + b;  // mod 2^32
            end
            op_cntz: begin
                for (int i = xlen - 1; i >= 0; i--) begin
                    if (a[i]) begin
                        seen = 1'b1;
                    end else if (!seen) begin
                        n++;
                    end
                end
                r = xlen'(n);
            end
            default:  r = '0;  // reserved
        endcase
        return r;
    endfunction

    // entered and left 5 units after an edge; samples 1 unit after an edge
    task automatic run_op(input logic [op_w-1:0] op, input logic [xlen-1:0] a,
                          input logic [xlen-1:0] b, input logic [xlen-1:0] exp);
        int   cycles;
        logic got;
        cycles = 0;
        got = 1'b0;
        op_i = op;
        rs1_i = a;
        rs2_i = b;
        unit_active_i = 1'b1;
        while (!got && cycles < ready_limit) begin
            @(posedge clk_i);
            #1;
            cycles++;
            got = ready_o;
        end
        if (!got) begin
            $display("timeout: no ready pulse within %0d cycles for op %0d",
                     ready_limit, op);
            timeouts++;
        end else begin
            check_value("ready latency", xlen'(cycles), xlen'(expected_latency(op)));
            check_value("result_o", result_o, exp);
            @(posedge clk_i);
            #1;
            check_value("ready_o", xlen'(ready_o), '0);  // single pulse
            check_value("result_o", result_o, exp);      // held while active
        end
        #4;
        unit_active_i = 1'b0;  // one idle cycle
        @(posedge clk_i);
        #1;
        check_value("result_o", result_o, '0);
        #4;
    endtask

    // start a counting op, drop active after n cycles, expect no ready
    task automatic abort_op(input logic [op_w-1:0] op, input logic [xlen-1:0] a,
                            input logic [xlen-1:0] b, input int n);
        op_i = op;
        rs1_i = a;
        rs2_i = b;
        unit_active_i = 1'b1;
        repeat (n) begin
            @(posedge clk_i);
            #1;
            check_value("ready_o", xlen'(ready_o), '0);
        end
        #4;
        unit_active_i = 1'b0;
        @(posedge clk_i);
        #1;
        check_value("ready_o", xlen'(ready_o), '0);
        check_value("result_o", result_o, '0);
        #4;
    endtask

    initial begin
        errors = 0;
        timeouts = 0;
        seed = 29;
        clk_i = 1'b0;
        reset_i = 1'b1;
        unit_active_i = 1'b0;
        op_i = '0;
        rs1_i = '0;
        rs2_i = '0;
        load_vector_table();

        repeat (16) @(posedge clk_i);
        #5;
        reset_i = 1'b0;
        @(posedge clk_i);
        #1;
        check_value("result_o", result_o, '0);  // clean after reset
        check_value("ready_o", xlen'(ready_o), '0);
        #4;

        for (int i = 0; i < vec_op.size(); i++) begin
            run_op(vec_op[i], vec_rs1[i], vec_rs2[i], vec_exp[i]);
        end

        // aborts mid count, each followed by a normal op
        abort_op(op_cntp, 32'hffff_ffff, 32'h0, 3);
        run_op(op_cntp, 32'hffff_ffff, 32'h0, 32'd32);
        abort_op(op_hmdst, 32'h1234_5678, 32'h0, 7);
        run_op(op_hmdst, 32'h0000_00ff, 32'h0000_0f0f, 32'd8);
        abort_op(op_cntz, 32'h0, 32'h0, 9);  // done already out, load blocked
        run_op(op_cntz, 32'h0000_0100, 32'h0, 32'd23);

        for (int k = 0; k < 40; k++) begin
            rnd = $random(seed);
            rnd_op = rnd[op_w-1:0];  // reserved codes too
            rnd_a = $random(seed);
            rnd_b = $random(seed);
            rnd = $random(seed);
            if (rnd_op == op_cntz) begin
                rnd_a = rnd_a >> rnd[4:0];  // spread leading zero counts
            end
            run_op(rnd_op, rnd_a, rnd_b, model_result(rnd_op, rnd_a, rnd_b));
        end

        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
